//--- source/issue_config.svh
// Issue stage configuration: lane count, station depth, field widths, branch opcode bits
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

`define ISSUE_LANES  2               // Dispatch lanes from rename
`define RS_DEPTH     4               // Entries per reservation station
`define PRF_AW       5               // Physical register address width
`define PRF_N        (1 << `PRF_AW)  // Physical register count
`define ROB_AW       4               // ROB slot id width
`define PC_W         64
`define DW           64              // Immediate width
`define ALU_OPC_W    8               // One-hot ALU opcode
`define BRU_OPC_W    8               // One-hot branch opcode
`define WB_CH        2               // Writeback channels into the busy table
`define PUSH_SIZE_W  2               // Holds 0..ISSUE_LANES

// Branch opcode bit positions
`define BRU_BEQ      0
`define BRU_BNE      1
`define BRU_BGT      2
`define BRU_BGTU     3
`define BRU_BLE      4
`define BRU_BLEU     5
`define BRU_JMPREL   6               // PC-relative jump
`define BRU_JMPREG   7               // Register-indirect jump

`endif

//--- source/issue_pkg.sv
// Issue stage package with field types and the reservation station entry layout
`include "issue_config.svh"

package issue_pkg;

   typedef logic [`PRF_AW-1:0]    prf_addr_t;   // Physical register address
   typedef logic [`ROB_AW-1:0]    rob_id_t;     // ROB slot
   typedef logic [`ALU_OPC_W-1:0] alu_opc_t;    // One-hot
   typedef logic [`BRU_OPC_W-1:0] bru_opc_t;    // One-hot

   // One station entry
   typedef struct packed
   {
      alu_opc_t                   alu_opc;
      bru_opc_t                   bru_opc;
      logic [`PC_W-1:0]           pc;
      logic [`DW-1:0]             imm;
      prf_addr_t                  prs1;         // Source 1
      logic                       prs1_re;      // Source 1 in use
      prf_addr_t                  prs2;         // Source 2
      logic                       prs2_re;      // Source 2 in use
      prf_addr_t                  prd;          // Destination
      logic                       prd_we;       // Destination written
      rob_id_t                    rob_id;       // Slot taken at dispatch
   } rs_payload_t;

endpackage

//--- source/busy_table.sv
// Busy table: one pending-write bit per physical register, set on dispatch, cleared on writeback
`timescale 1ns/1ps
`include "issue_config.svh"

module busy_table
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic [`ISSUE_LANES-1:0]           set_we,     // Dispatch with destination write
   input  logic [`ISSUE_LANES*`PRF_AW-1:0]   set_prd,    // Lane i in slice i
   input  logic [`WB_CH-1:0]                 wb_we,      // Writeback strobes
   input  logic [`WB_CH*`PRF_AW-1:0]         wb_prd,     // Channel i in slice i
   output logic [`PRF_N-1:0]                 busy
);

   logic [`PRF_N-1:0]                        busy_q;
   logic [`PRF_N-1:0]                        busy_nxt;

   // Clears first so that a same-edge set overrides them
   always_comb
   begin
      busy_nxt = busy_q;
      for (int w = 0; w < `WB_CH; w++)
      begin
         if (wb_we[w])
            busy_nxt[wb_prd[w*`PRF_AW +: `PRF_AW]] = 1'b0;   // Result written back
      end
      for (int l = 0; l < `ISSUE_LANES; l++)
      begin
         if (set_we[l])
            busy_nxt[set_prd[l*`PRF_AW +: `PRF_AW]] = 1'b1;  // New producer in flight
      end
      busy_nxt[0] = 1'b0;                                    // r0 is hardwired
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         busy_q <= '0;
      else
         busy_q <= busy_nxt;
   end

   // Registered only, so wakeup is seen the cycle after the writeback edge
   assign busy = busy_q;

endmodule

//--- source/issue_rs.sv
// Issue reservation station with a compacting age-ordered queue and oldest-ready selection
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_rs
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        push,          // Accepted instruction this cycle
   input  issue_pkg::rs_payload_t      push_payload,
   input  logic [`PRF_N-1:0]           busy,          // From busy table
   output logic                        full,
   input  logic                        ro_ready,
   output logic                        ro_valid,
   output issue_pkg::rs_payload_t      ro_payload
);

   localparam int SEL_W = $clog2(`RS_DEPTH);

   // Entry 0 is the oldest and valid bits stay packed toward 0
   issue_pkg::rs_payload_t             ent_q [`RS_DEPTH];
   issue_pkg::rs_payload_t             ent_nxt [`RS_DEPTH];
   logic [`RS_DEPTH-1:0]               vld_q;
   logic [`RS_DEPTH-1:0]               vld_nxt;
   logic [`RS_DEPTH-1:0]               rdy;           // Valid and all sources available
   logic [SEL_W-1:0]                   sel;           // Oldest ready entry
   logic                               pop;

   // Wakeup check per entry
   always_comb
   begin
      for (int i = 0; i < `RS_DEPTH; i++)
      begin
         rdy[i] = vld_q[i] &
                  (~ent_q[i].prs1_re | (ent_q[i].prs1 == '0) | ~busy[ent_q[i].prs1]) &
                  (~ent_q[i].prs2_re | (ent_q[i].prs2 == '0) | ~busy[ent_q[i].prs2]);
      end
   end

   // Priority pick from the young end so the lowest index wins
   always_comb
   begin
      sel = '0;
      for (int i = `RS_DEPTH-1; i >= 0; i--)
      begin
         if (rdy[i])
            sel = SEL_W'(i);
      end
   end

   assign ro_valid   = |rdy;
   assign ro_payload = ent_q[sel];                   // Don't-care when nothing ready
   assign pop        = ro_valid & ro_ready;
   assign full       = &vld_q;

   // Remove the popped slot and then append the push
   always_comb
   begin
      logic placed;

      placed  = 1'b0;
      vld_nxt = vld_q;
      ent_nxt = ent_q;

      if (pop)
      begin
         for (int i = 0; i < `RS_DEPTH-1; i++)
         begin
            if (i >= sel)
            begin
               vld_nxt[i] = vld_q[i+1];              // Younger entries slide down
               ent_nxt[i] = ent_q[i+1];
            end
         end
         vld_nxt[`RS_DEPTH-1] = 1'b0;                // Top slot always frees on a pop
      end

      // First hole after the shift keeps age order
      if (push)
      begin
         for (int i = 0; i < `RS_DEPTH; i++)
         begin
            if (!vld_nxt[i] && !placed)
            begin
               vld_nxt[i] = 1'b1;
               ent_nxt[i] = push_payload;
               placed     = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         vld_q <= '0;
      else
         vld_q <= vld_nxt;
   end

   // Entry payload storage
   always_ff @(posedge clk)
   begin
      ent_q <= ent_nxt;
   end

endmodule

//--- source/issue.sv
// Issue stage: per-lane reservation stations, push gating, ROB push and branch classification
`timescale 1ns/1ps
`include "issue_config.svh"

module issue
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic [`PRF_N-1:0]                       busy,
   // From rename
   input  logic                                    issue_p_ce,     // Commits a push group
   input  logic [`ISSUE_LANES-1:0]                 issue_push,
   input  issue_pkg::alu_opc_t [`ISSUE_LANES-1:0]  issue_alu_opc,
   input  issue_pkg::bru_opc_t [`ISSUE_LANES-1:0]  issue_bru_opc,
   input  logic [`ISSUE_LANES-1:0][`PC_W-1:0]      issue_pc,
   input  logic [`ISSUE_LANES-1:0][`DW-1:0]        issue_imm,
   input  issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] issue_prs1,
   input  logic [`ISSUE_LANES-1:0]                 issue_prs1_re,
   input  issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] issue_prs2,
   input  logic [`ISSUE_LANES-1:0]                 issue_prs2_re,
   input  issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] issue_prd,
   input  logic [`ISSUE_LANES-1:0]                 issue_prd_we,
   output logic [`ISSUE_LANES-1:0]                 issue_ready,
   // ROB
   input  logic                                    rob_ready,
   input  issue_pkg::rob_id_t [`ISSUE_LANES-1:0]   rob_free_id,    // Offered slot per lane
   output logic [`ISSUE_LANES-1:0]                 rob_push_valid,
   output logic [`ISSUE_LANES-1:0][`PC_W-1:0]      rob_push_pc,
   output issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] rob_push_prd,
   output logic [`ISSUE_LANES-1:0]                 rob_push_prd_we,
   output logic [`ISSUE_LANES-1:0]                 rob_push_is_bcc,
   output logic [`ISSUE_LANES-1:0]                 rob_push_is_brel,
   output logic [`ISSUE_LANES-1:0]                 rob_push_is_breg,
   output logic [`PUSH_SIZE_W-1:0]                 rob_push_size,
   // Read stage
   input  logic [`ISSUE_LANES-1:0]                 ro_ready,
   output logic [`ISSUE_LANES-1:0]                 ro_valid,
   output issue_pkg::alu_opc_t [`ISSUE_LANES-1:0]  ro_alu_opc,
   output issue_pkg::bru_opc_t [`ISSUE_LANES-1:0]  ro_bru_opc,
   output logic [`ISSUE_LANES-1:0][`PC_W-1:0]      ro_pc,
   output logic [`ISSUE_LANES-1:0][`DW-1:0]        ro_imm,
   output issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] ro_prs1,
   output logic [`ISSUE_LANES-1:0]                 ro_prs1_re,
   output issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] ro_prs2,
   output logic [`ISSUE_LANES-1:0]                 ro_prs2_re,
   output issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] ro_prd,
   output logic [`ISSUE_LANES-1:0]                 ro_prd_we,
   output issue_pkg::rob_id_t [`ISSUE_LANES-1:0]   ro_rob_id,
   // To busy table
   output logic [`ISSUE_LANES-1:0]                 accept          // Accepted and writes prd
);

   issue_pkg::rs_payload_t                         rs_in [`ISSUE_LANES];
   issue_pkg::rs_payload_t                         rs_out [`ISSUE_LANES];
   logic [`ISSUE_LANES-1:0]                        rs_full;
   logic [`ISSUE_LANES-1:0]                        lane_push;      // Lane taken this edge

   genvar i;

   assign issue_ready = ~rs_full & {`ISSUE_LANES{rob_ready}};
   assign lane_push   = issue_push & issue_ready & {`ISSUE_LANES{issue_p_ce}};
   assign accept      = lane_push & issue_prd_we;

   // ROB bookkeeping, same cycle as acceptance
   assign rob_push_valid  = lane_push;
   assign rob_push_pc     = issue_pc;
   assign rob_push_prd    = issue_prd;
   assign rob_push_prd_we = issue_prd_we;

   always_comb
   begin
      rob_push_size = '0;
      for (int l = 0; l < `ISSUE_LANES; l++)
         rob_push_size = rob_push_size + lane_push[l];   // Count of accepted lanes
   end

   generate
      for (i = 0; i < `ISSUE_LANES; i++)
      begin : gen_lane
         // Branch kind for the ROB
         assign rob_push_is_bcc[i]  = issue_bru_opc[i][`BRU_BEQ]  | issue_bru_opc[i][`BRU_BNE] |
                                      issue_bru_opc[i][`BRU_BGT]  | issue_bru_opc[i][`BRU_BGTU] |
                                      issue_bru_opc[i][`BRU_BLE]  | issue_bru_opc[i][`BRU_BLEU];
         assign rob_push_is_brel[i] = issue_bru_opc[i][`BRU_JMPREL];
         assign rob_push_is_breg[i] = issue_bru_opc[i][`BRU_JMPREG];

         assign rs_in[i] = '{alu_opc: issue_alu_opc[i],
                             bru_opc: issue_bru_opc[i],
                             pc:      issue_pc[i],
                             imm:     issue_imm[i],
                             prs1:    issue_prs1[i],
                             prs1_re: issue_prs1_re[i],
                             prs2:    issue_prs2[i],
                             prs2_re: issue_prs2_re[i],
                             prd:     issue_prd[i],
                             prd_we:  issue_prd_we[i],
                             rob_id:  rob_free_id[i]};   // ROB slot rides with the entry

         issue_rs u_rs
         (
            .clk          (clk),
            .reset        (reset),
            .push         (lane_push[i]),
            .push_payload (rs_in[i]),
            .busy         (busy),
            .full         (rs_full[i]),
            .ro_ready     (ro_ready[i]),
            .ro_valid     (ro_valid[i]),
            .ro_payload   (rs_out[i])
         );

         // Selected entry onto the read-stage buses
         assign ro_alu_opc[i] = rs_out[i].alu_opc;
         assign ro_bru_opc[i] = rs_out[i].bru_opc;
         assign ro_pc[i]      = rs_out[i].pc;
         assign ro_imm[i]     = rs_out[i].imm;
         assign ro_prs1[i]    = rs_out[i].prs1;
         assign ro_prs1_re[i] = rs_out[i].prs1_re;
         assign ro_prs2[i]    = rs_out[i].prs2;
         assign ro_prs2_re[i] = rs_out[i].prs2_re;
         assign ro_prd[i]     = rs_out[i].prd;
         assign ro_prd_we[i]  = rs_out[i].prd_we;
         assign ro_rob_id[i]  = rs_out[i].rob_id;
      end
   endgenerate

endmodule

//--- source/issue_unit.sv
// Issue unit top: issue stage with the busy table that steers its wakeup
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_unit
(
   input  logic                                    clk,
   input  logic                                    reset,
   // Rename
   input  logic                                    issue_p_ce,
   input  logic [`ISSUE_LANES-1:0]                 issue_push,
   input  issue_pkg::alu_opc_t [`ISSUE_LANES-1:0]  issue_alu_opc,
   input  issue_pkg::bru_opc_t [`ISSUE_LANES-1:0]  issue_bru_opc,
   input  logic [`ISSUE_LANES-1:0][`PC_W-1:0]      issue_pc,
   input  logic [`ISSUE_LANES-1:0][`DW-1:0]        issue_imm,
   input  issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] issue_prs1,
   input  logic [`ISSUE_LANES-1:0]                 issue_prs1_re,
   input  issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] issue_prs2,
   input  logic [`ISSUE_LANES-1:0]                 issue_prs2_re,
   input  issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] issue_prd,
   input  logic [`ISSUE_LANES-1:0]                 issue_prd_we,
   output logic [`ISSUE_LANES-1:0]                 issue_ready,
   // ROB
   input  logic                                    rob_ready,
   input  issue_pkg::rob_id_t [`ISSUE_LANES-1:0]   rob_free_id,
   output logic [`ISSUE_LANES-1:0]                 rob_push_valid,
   output logic [`ISSUE_LANES-1:0][`PC_W-1:0]      rob_push_pc,
   output issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] rob_push_prd,
   output logic [`ISSUE_LANES-1:0]                 rob_push_prd_we,
   output logic [`ISSUE_LANES-1:0]                 rob_push_is_bcc,
   output logic [`ISSUE_LANES-1:0]                 rob_push_is_brel,
   output logic [`ISSUE_LANES-1:0]                 rob_push_is_breg,
   output logic [`PUSH_SIZE_W-1:0]                 rob_push_size,
   // Read stage
   input  logic [`ISSUE_LANES-1:0]                 ro_ready,
   output logic [`ISSUE_LANES-1:0]                 ro_valid,
   output issue_pkg::alu_opc_t [`ISSUE_LANES-1:0]  ro_alu_opc,
   output issue_pkg::bru_opc_t [`ISSUE_LANES-1:0]  ro_bru_opc,
   output logic [`ISSUE_LANES-1:0][`PC_W-1:0]      ro_pc,
   output logic [`ISSUE_LANES-1:0][`DW-1:0]        ro_imm,
   output issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] ro_prs1,
   output logic [`ISSUE_LANES-1:0]                 ro_prs1_re,
   output issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] ro_prs2,
   output logic [`ISSUE_LANES-1:0]                 ro_prs2_re,
   output issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] ro_prd,
   output logic [`ISSUE_LANES-1:0]                 ro_prd_we,
   output issue_pkg::rob_id_t [`ISSUE_LANES-1:0]   ro_rob_id,
   // Writeback
   input  logic [`WB_CH-1:0]                       wb_we,
   input  issue_pkg::prf_addr_t [`WB_CH-1:0]       wb_prd
);

   logic [`PRF_N-1:0]                              busy;     // Pending-write bits
   logic [`ISSUE_LANES-1:0]                        accept;   // Dispatches that set busy

   busy_table u_busy_table
   (
      .clk     (clk),
      .reset   (reset),
      .set_we  (accept),
      .set_prd (issue_prd),
      .wb_we   (wb_we),
      .wb_prd  (wb_prd),
      .busy    (busy)
   );

   issue u_issue
   (
      .clk              (clk),
      .reset            (reset),
      .busy             (busy),
      .issue_p_ce       (issue_p_ce),
      .issue_push       (issue_push),
      .issue_alu_opc    (issue_alu_opc),
      .issue_bru_opc    (issue_bru_opc),
      .issue_pc         (issue_pc),
      .issue_imm        (issue_imm),
      .issue_prs1       (issue_prs1),
      .issue_prs1_re    (issue_prs1_re),
      .issue_prs2       (issue_prs2),
      .issue_prs2_re    (issue_prs2_re),
      .issue_prd        (issue_prd),
      .issue_prd_we     (issue_prd_we),
      .issue_ready      (issue_ready),
      .rob_ready        (rob_ready),
      .rob_free_id      (rob_free_id),
      .rob_push_valid   (rob_push_valid),
      .rob_push_pc      (rob_push_pc),
      .rob_push_prd     (rob_push_prd),
      .rob_push_prd_we  (rob_push_prd_we),
      .rob_push_is_bcc  (rob_push_is_bcc),
      .rob_push_is_brel (rob_push_is_brel),
      .rob_push_is_breg (rob_push_is_breg),
      .rob_push_size    (rob_push_size),
      .ro_ready         (ro_ready),
      .ro_valid         (ro_valid),
      .ro_alu_opc       (ro_alu_opc),
      .ro_bru_opc       (ro_bru_opc),
      .ro_pc            (ro_pc),
      .ro_imm           (ro_imm),
      .ro_prs1          (ro_prs1),
      .ro_prs1_re       (ro_prs1_re),
      .ro_prs2          (ro_prs2),
      .ro_prs2_re       (ro_prs2_re),
      .ro_prd           (ro_prd),
      .ro_prd_we        (ro_prd_we),
      .ro_rob_id        (ro_rob_id),
      .accept           (accept)
   );

endmodule

//--- bench/tb_clock.sv
// Testbench clock source with a 100 ns period
`timescale 1ns/1ps

module tb_clock
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;                       // Half period
   end

endmodule

//--- bench/issue_tb.sv
// Issue unit testbench with random dispatch, writeback and read stalls checked against a model
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_tb;

   logic                                    clk;
   logic                                    reset;
   logic                                    issue_p_ce;
   logic [`ISSUE_LANES-1:0]                 issue_push;
   issue_pkg::alu_opc_t [`ISSUE_LANES-1:0]  issue_alu_opc;
   issue_pkg::bru_opc_t [`ISSUE_LANES-1:0]  issue_bru_opc;
   logic [`ISSUE_LANES-1:0][`PC_W-1:0]      issue_pc;
   logic [`ISSUE_LANES-1:0][`DW-1:0]        issue_imm;
   issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] issue_prs1;
   logic [`ISSUE_LANES-1:0]                 issue_prs1_re;
   issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] issue_prs2;
   logic [`ISSUE_LANES-1:0]                 issue_prs2_re;
   issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] issue_prd;
   logic [`ISSUE_LANES-1:0]                 issue_prd_we;
   logic [`ISSUE_LANES-1:0]                 issue_ready;
   logic                                    rob_ready;
   issue_pkg::rob_id_t [`ISSUE_LANES-1:0]   rob_free_id;
   logic [`ISSUE_LANES-1:0]                 rob_push_valid;
   logic [`ISSUE_LANES-1:0][`PC_W-1:0]      rob_push_pc;
   issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] rob_push_prd;
   logic [`ISSUE_LANES-1:0]                 rob_push_prd_we;
   logic [`ISSUE_LANES-1:0]                 rob_push_is_bcc;
   logic [`ISSUE_LANES-1:0]                 rob_push_is_brel;
   logic [`ISSUE_LANES-1:0]                 rob_push_is_breg;
   logic [`PUSH_SIZE_W-1:0]                 rob_push_size;
   logic [`ISSUE_LANES-1:0]                 ro_ready;
   logic [`ISSUE_LANES-1:0]                 ro_valid;
   issue_pkg::alu_opc_t [`ISSUE_LANES-1:0]  ro_alu_opc;
   issue_pkg::bru_opc_t [`ISSUE_LANES-1:0]  ro_bru_opc;
   logic [`ISSUE_LANES-1:0][`PC_W-1:0]      ro_pc;
   logic [`ISSUE_LANES-1:0][`DW-1:0]        ro_imm;
   issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] ro_prs1;
   logic [`ISSUE_LANES-1:0]                 ro_prs1_re;
   issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] ro_prs2;
   logic [`ISSUE_LANES-1:0]                 ro_prs2_re;
   issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] ro_prd;
   logic [`ISSUE_LANES-1:0]                 ro_prd_we;
   issue_pkg::rob_id_t [`ISSUE_LANES-1:0]   ro_rob_id;
   logic [`WB_CH-1:0]                       wb_we;
   issue_pkg::prf_addr_t [`WB_CH-1:0]       wb_prd;

   issue_pkg::rs_payload_t                  model_q [`ISSUE_LANES][`RS_DEPTH];  // Oldest first
   int                                      model_cnt [`ISSUE_LANES];
   logic [`PRF_N-1:0]                       model_busy;

   integer                                  seed;
   logic                                    push_en;     // Random pushes allowed
   logic                                    wb_en;       // Random writebacks allowed
   int                                      src_mode;    // 0 r0 or unused, 1 small pool
   int                                      ro_mode;     // 0 random, 1 low, 2 high
   int                                      n_chk;
   int                                      n_err;
   int                                      err_base;
   int                                      n_test;

   tb_clock u_clock (.clk(clk));

   issue_unit i_dut (.*);

   task check_eq(input logic [255:0] got, input logic [255:0] exp, input string what);
      n_chk++;
      if (got !== exp)
      begin
         n_err++;
         $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   // Enabled source must be r0 or not pending
   function automatic logic entry_ready(input issue_pkg::rs_payload_t e);
      return (!e.prs1_re || e.prs1 == '0 || !model_busy[e.prs1]) &&
             (!e.prs2_re || e.prs2 == '0 || !model_busy[e.prs2]);
   endfunction

   function automatic issue_pkg::rs_payload_t entry_from_inputs(input int l);
      issue_pkg::rs_payload_t e;
      e.alu_opc = issue_alu_opc[l];
      e.bru_opc = issue_bru_opc[l];
      e.pc      = issue_pc[l];
      e.imm     = issue_imm[l];
      e.prs1    = issue_prs1[l];
      e.prs1_re = issue_prs1_re[l];
      e.prs2    = issue_prs2[l];
      e.prs2_re = issue_prs2_re[l];
      e.prd     = issue_prd[l];
      e.prd_we  = issue_prd_we[l];
      e.rob_id  = rob_free_id[l];                  // Offered slot at acceptance
      return e;
   endfunction

   function automatic issue_pkg::rs_payload_t entry_from_ro(input int l);
      issue_pkg::rs_payload_t e;
      e.alu_opc = ro_alu_opc[l];
      e.bru_opc = ro_bru_opc[l];
      e.pc      = ro_pc[l];
      e.imm     = ro_imm[l];
      e.prs1    = ro_prs1[l];
      e.prs1_re = ro_prs1_re[l];
      e.prs2    = ro_prs2[l];
      e.prs2_re = ro_prs2_re[l];
      e.prd     = ro_prd[l];
      e.prd_we  = ro_prd_we[l];
      e.rob_id  = ro_rob_id[l];
      return e;
   endfunction

   task idle_inputs();
      issue_p_ce    <= 1'b0;
      issue_push    <= '0;
      issue_alu_opc <= '0;
      issue_bru_opc <= '0;
      issue_pc      <= '0;
      issue_imm     <= '0;
      issue_prs1    <= '0;
      issue_prs1_re <= '0;
      issue_prs2    <= '0;
      issue_prs2_re <= '0;
      issue_prd     <= '0;
      issue_prd_we  <= '0;
      rob_ready     <= 1'b1;
      rob_free_id   <= '0;
      ro_ready      <= '1;
      wb_we         <= '0;
      wb_prd        <= '0;
   endtask

   task apply_reset();
      @(posedge clk);
      reset <= 1'b1;
      idle_inputs();
      repeat (3) @(posedge clk);                   // Three cycles in reset
      reset <= 1'b0;
      for (int l = 0; l < `ISSUE_LANES; l++)
         model_cnt[l] = 0;
      model_busy = '0;
   endtask

   // Builds whole vectors and drives each input once at the rising edge
   task drive_random();
      logic [`ISSUE_LANES-1:0]                 push;
      logic [`ISSUE_LANES-1:0]                 re1;
      logic [`ISSUE_LANES-1:0]                 re2;
      logic [`ISSUE_LANES-1:0]                 we;
      issue_pkg::alu_opc_t [`ISSUE_LANES-1:0]  alu;
      issue_pkg::bru_opc_t [`ISSUE_LANES-1:0]  bru;
      logic [`ISSUE_LANES-1:0][`PC_W-1:0]      pc;
      logic [`ISSUE_LANES-1:0][`DW-1:0]        imm;
      issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] prs1;
      issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] prs2;
      issue_pkg::prf_addr_t [`ISSUE_LANES-1:0] prd;
      issue_pkg::rob_id_t [`ISSUE_LANES-1:0]   rid;
      logic [`WB_CH-1:0]                       wwe;
      issue_pkg::prf_addr_t [`WB_CH-1:0]       wprd;
      logic [7:0]                              mask;
      @(posedge clk);
      mask = (src_mode == 0) ? 8'd31 : 8'd7;      // Small pool makes dependencies common
      for (int l = 0; l < `ISSUE_LANES; l++)
      begin
         push[l] = push_en & ($random(seed) & 1);
         alu[l]  = 8'(1 << ($random(seed) & 7));
         case ($random(seed) & 3)
            0:       bru[l] = '0;
            1:       bru[l] = $random(seed);       // Arbitrary bit mix
            default: bru[l] = 8'(1 << ($random(seed) & 7));
         endcase
         pc[l]   = {$random(seed), $random(seed)};
         imm[l]  = {$random(seed), $random(seed)};
         re1[l]  = $random(seed);
         re2[l]  = $random(seed);
         prs1[l] = (src_mode == 0 && re1[l]) ? 5'd0 : 5'($random(seed) & mask);
         prs2[l] = (src_mode == 0 && re2[l]) ? 5'd0 : 5'($random(seed) & mask);
         prd[l]  = 5'($random(seed) & mask);
         we[l]   = $random(seed);
         rid[l]  = $random(seed);
      end
      for (int c = 0; c < `WB_CH; c++)
      begin
         wwe[c]  = wb_en & ($random(seed) & 1);
         wprd[c] = 5'($random(seed) & 7);
      end
      issue_p_ce    <= ($random(seed) & 3) != 0;    // Mostly committing
      issue_push    <= push;
      issue_alu_opc <= alu;
      issue_bru_opc <= bru;
      issue_pc      <= pc;
      issue_imm     <= imm;
      issue_prs1    <= prs1;
      issue_prs1_re <= re1;
      issue_prs2    <= prs2;
      issue_prs2_re <= re2;
      issue_prd     <= prd;
      issue_prd_we  <= we;
      rob_ready     <= (ro_mode == 1) ? 1'b1 : (($random(seed) & 7) != 0);
      rob_free_id   <= rid;
      case (ro_mode)
         0:       ro_ready <= $random(seed);
         1:       ro_ready <= '0;
         default: ro_ready <= '1;
      endcase
      wb_we         <= wwe;
      wb_prd        <= wprd;
   endtask

   // Compares mid-cycle and then steps the model to the next edge
   task check_cycle();
      logic [`ISSUE_LANES-1:0] exp_rdy;
      logic [`ISSUE_LANES-1:0] exp_acc;
      int                      sel;
      @(negedge clk);
      for (int l = 0; l < `ISSUE_LANES; l++)
      begin
         exp_rdy[l] = (model_cnt[l] < `RS_DEPTH) && rob_ready;
         exp_acc[l] = issue_p_ce && issue_push[l] && exp_rdy[l];
      end
      check_eq(issue_ready, exp_rdy, "issue_ready");
      check_eq(rob_push_valid, exp_acc, "rob_push_valid");
      check_eq(rob_push_size, $countones(exp_acc), "rob_push_size");
      for (int l = 0; l < `ISSUE_LANES; l++)
      begin
         if (exp_acc[l])
         begin
            check_eq(rob_push_pc[l], issue_pc[l], $sformatf("rob_push_pc lane %0d", l));
            check_eq(rob_push_prd[l], issue_prd[l], $sformatf("rob_push_prd lane %0d", l));
            check_eq(rob_push_prd_we[l], issue_prd_we[l], $sformatf("prd_we lane %0d", l));
            check_eq(rob_push_is_bcc[l], |issue_bru_opc[l][`BRU_BLEU:`BRU_BEQ],
                     $sformatf("is_bcc lane %0d", l));
            check_eq(rob_push_is_brel[l], issue_bru_opc[l][`BRU_JMPREL],
                     $sformatf("is_brel lane %0d", l));
            check_eq(rob_push_is_breg[l], issue_bru_opc[l][`BRU_JMPREG],
                     $sformatf("is_breg lane %0d", l));
         end
         sel = -1;                                 // Oldest ready entry
         for (int i = 0; i < model_cnt[l]; i++)
            if (sel < 0 && entry_ready(model_q[l][i]))
               sel = i;
         check_eq(ro_valid[l], sel >= 0, $sformatf("ro_valid lane %0d", l));
         if (sel >= 0)
         begin
            check_eq(entry_from_ro(l), model_q[l][sel], $sformatf("ro payload lane %0d", l));
            if (ro_ready[l])
            begin
               for (int i = sel; i < `RS_DEPTH-1; i++)
                  model_q[l][i] = model_q[l][i+1];
               model_cnt[l]--;
            end
         end
         if (exp_acc[l])
         begin
            model_q[l][model_cnt[l]] = entry_from_inputs(l);
            model_cnt[l]++;
         end
      end
      for (int c = 0; c < `WB_CH; c++)
         if (wb_we[c])
            model_busy[wb_prd[c]] = 1'b0;
      for (int l = 0; l < `ISSUE_LANES; l++)       // Dispatch set beats writeback clear
         if (exp_acc[l] && issue_prd_we[l])
            model_busy[issue_prd[l]] = 1'b1;
      model_busy[0] = 1'b0;
   endtask

   task run_random(input int n);
      repeat (n)
      begin
         drive_random();
         check_cycle();
      end
   endtask

   task drain(input string what);
      int guard;
      guard   = 0;
      push_en = 1'b0;
      ro_mode = 2;
      while ((model_cnt[0] != 0 || model_cnt[1] != 0 || ro_valid != '0) && guard < 200)
      begin
         drive_random();
         check_cycle();
         guard++;
      end
      if (model_cnt[0] != 0 || model_cnt[1] != 0 || ro_valid != '0)
      begin
         n_err++;
         $display("timeout: the stations did not drain after %s within 200 cycles", what);
      end
   endtask

   task end_test(input string name);
      n_test++;
      $display("test %0d %s finished with %0d errors", n_test, name, n_err - err_base);
      err_base = n_err;
   endtask

   initial
   begin
      int                     guard;
      issue_pkg::rs_payload_t held;
      seed     = 50282;
      n_chk    = 0;
      n_err    = 0;
      err_base = 0;
      n_test   = 0;
      reset   <= 1'b1;
      idle_inputs();
      apply_reset();

      // Idle state out of reset
      check_cycle();
      check_eq(ro_valid, '0, "ro_valid after reset");
      check_eq(rob_push_valid, '0, "rob_push_valid after reset");
      check_eq(rob_push_size, '0, "rob_push_size after reset");
      check_eq(issue_ready, {`ISSUE_LANES{1'b1}}, "issue_ready after reset");
      @(posedge clk);
      idle_inputs();
      rob_ready <= 1'b0;
      check_cycle();
      check_eq(issue_ready, '0, "issue_ready with rob_ready low");
      end_test("reset and rob_ready");

      push_en  = 1'b1;
      wb_en    = 1'b0;
      src_mode = 0;
      ro_mode  = 2;
      run_random(200);
      drain("rob push");
      end_test("rob push and branch class");

      push_en = 1'b1;
      ro_mode = 0;
      run_random(300);
      drain("in-order flow");
      end_test("in-order flow");

      push_en  = 1'b1;
      wb_en    = 1'b1;
      src_mode = 1;
      ro_mode  = 0;
      run_random(400);
      drain("dependency wakeup");                  // Writebacks keep running
      wb_en    = 1'b0;
      end_test("dependency wakeup");

      push_en  = 1'b1;
      src_mode = 0;
      ro_mode  = 1;
      guard    = 0;
      while (issue_ready[0] && guard < 100)        // Wait for lane 0 to fill
      begin
         drive_random();
         check_cycle();
         guard++;
      end
      if (issue_ready[0])
      begin
         n_err++;
         $display("timeout: lane 0 station never filled within 100 cycles");
      end
      held = model_q[0][0];                        // Oldest entry stays selected
      repeat (6)
      begin
         drive_random();
         check_cycle();
         check_eq(issue_ready[0], 1'b0, "issue_ready lane 0 while full");
         check_eq(entry_from_ro(0), held, "lane 0 outputs held under stall");
      end
      drain("back-pressure");
      end_test("back-pressure");

      apply_reset();
      @(posedge clk);                              // Producer of r9
      idle_inputs();
      issue_p_ce   <= 1'b1;
      issue_push   <= 2'b01;
      issue_prd    <= {5'd0, 5'd9};
      issue_prd_we <= 2'b01;
      check_cycle();
      @(posedge clk);                              // New producer and writeback on r9 together
      idle_inputs();
      issue_p_ce   <= 1'b1;
      issue_push   <= 2'b01;
      issue_prd    <= {5'd0, 5'd9};
      issue_prd_we <= 2'b01;
      wb_we        <= 2'b01;
      wb_prd       <= {5'd0, 5'd9};
      check_cycle();
      @(posedge clk);                              // Reader of r9 on lane 1
      idle_inputs();
      issue_p_ce    <= 1'b1;
      issue_push    <= 2'b10;
      issue_prs1    <= {5'd9, 5'd0};
      issue_prs1_re <= 2'b10;
      check_cycle();
      repeat (4)
      begin
         @(posedge clk);
         idle_inputs();
         check_cycle();
         check_eq(ro_valid[1], 1'b0, "reader waits on busy r9");
      end
      @(posedge clk);
      idle_inputs();
      wb_we  <= 2'b10;
      wb_prd <= {5'd9, 5'd0};
      check_cycle();
      guard = 0;
      while (!ro_valid[1] && guard < 10)
      begin
         @(posedge clk);
         idle_inputs();
         check_cycle();
         guard++;
      end
      if (!ro_valid[1])
      begin
         n_err++;
         $display("timeout: reader of r9 never issued after its writeback");
      end
      check_eq(ro_prs1[1], 5'd9, "reader source after wakeup");
      drain("set and clear");
      end_test("set and clear together");

      $display("tests %0d, checks %0d, errors %0d", n_test, n_chk, n_err);
      if (n_err == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- build.f
+incdir+source
source/issue_pkg.sv
source/busy_table.sv
source/issue_rs.sv
source/issue.sv
source/issue_unit.sv
bench/tb_clock.sv
bench/issue_tb.sv
